// ==== verilog.f ====
+incdir+hdl
hdl/nfcProgramPkg.sv
hdl/pageProgramSequencer.sv
hdl/cycleRequestBuilder.sv
hdl/nfcProgramPage.sv
test/nfcProgramPage_assert.sv
test/tbNfcProgramPage.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal -f verilog.f \
    --top-module tbNfcProgramPage -o simNfcProgramPage
./obj_dir/simNfcProgramPage 2>&1 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
grep -q "TESTS PASSED" sim.log

// ==== test/tbNfcProgramPage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nfc_defines.svh"

module tbNfcProgramPage
    import nfcProgramPkg::*;
();

    logic               iSystemClock;
    logic               rstN;
    logic               cmdValid;
    pageCommand_t       cmd;
    logic [`PRIM_W-1:0] primDone;
    logic               cmdReady;
    logic               start;
    logic               lastStep;
    primRequest_t       request;

    int           errorCount;
    int           timeoutCount;
    logic [31:0]  lcgState = 32'd34;
    primRequest_t seenQ[$];
    logic         engineBusy;
    int           engineCount;

    nfcProgramPage UUT (.*);

    initial iSystemClock = 1'b0;
    always #10 iSystemClock = ~iSystemClock;

    // upper bits only since the low ones repeat quickly
    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {8'h00, lcgState[31:8]};
    endfunction

    task automatic checkValue(input logic [63:0] got, input logic [63:0] exp, input string what);
        assert (got === exp) else begin
            errorCount++;
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic reportTimeout(input string what);
        timeoutCount++;
        $display("timeout at %0t ns: %s never came", $time, what);
    endtask

    // engine model answering each request after 1 to 4 cycles
    initial begin
        primDone = '0;
        engineBusy = 1'b0;
        engineCount = 0;
        forever begin
            @(posedge iSystemClock);
            #2;
            if (primDone != '0) begin
                primDone = '0;
                engineBusy = 1'b0;
            end else if (engineBusy) begin
                engineCount--;
                if (engineCount == 0) begin
                    primDone = request.stepSelect;
                end
            end
            if (rstN && !engineBusy && request.stepSelect != '0) begin
                seenQ.push_back(request);
                engineBusy = 1'b1;
                engineCount = 1 + int'(nextRandom() % 4);
            end
        end
    end

    function automatic pageCommand_t makeCommand(input logic [`OPTION_W-1:0] option,
        input logic [`LEN_W-1:0] length, input logic [`WAY_COUNT-1:0] wayMask,
        input logic [`COL_W-1:0] col, input logic [`ROW_W-1:0] row);
        pageCommand_t c;
        c.opcode = `PROGRAM_PAGE_OPCODE;
        c.option = option;
        c.length = length;
        c.wayMask = wayMask;
        c.colAddress = col;
        c.rowAddress = row;
        return c;
    endfunction

    function automatic pageCommand_t randomCommand();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = nextRandom();
        b = nextRandom();
        c = nextRandom();
        // column low goes out first so it stays off command bytes
        if (a[7:0] inside {8'h80, 8'h10, 8'h11, 8'h15}) begin
            a[7:0] = a[7:0] ^ 8'h40;
        end
        return makeCommand(c[20:16], c[15:0], a[19:16], a[15:0], b[23:0]);
    endfunction

    // expected request per step index from setup through confirm
    function automatic primRequest_t expectedStep(input pageCommand_t c, input int idx);
        primRequest_t r;
        logic [39:0]  addr;
        logic [7:0]   confirm;
        int           k;
        r = '0;
        r.wayMask = c.wayMask;
        r.caSelect = 1'b1;
        addr = {c.rowAddress, c.colAddress};
        case (c.option[1:0])
            2'b01: confirm = 8'h15;
            2'b10: confirm = 8'h11;
            default: confirm = 8'h10;
        endcase
        case (idx)
            0: begin
                r.stepSelect = 8'h08;
                r.caData[39:32] = 8'h80;
            end
            1: begin
                r.stepSelect = 8'h08;
                r.caSelect = 1'b0;
                r.numOfData = 16'd4;
                // low byte of the address goes out first
                for (k = 0; k < 5; k++) begin
                    r.caData = {r.caData[31:0], addr[8*k +: 8]};
                end
            end
            2: begin
                r.stepSelect = 8'h04;
                r.caSelect = 1'b0;
                r.numOfData = c.length;
            end
            default: begin
                r.stepSelect = 8'h08;
                r.caData[39:32] = confirm;
            end
        endcase
        return r;
    endfunction

    task automatic waitIdle();
        int cycles;
        cycles = 0;
        while (!cmdReady && cycles < 200) begin
            @(posedge iSystemClock);
            #2;
            cycles++;
        end
        if (!cmdReady) begin
            reportTimeout("cmdReady");
        end
    endtask

    task automatic checkResetValues();
        checkValue(cmdReady, 1, "cmdReady after reset");
        checkValue(lastStep, 0, "lastStep after reset");
        checkValue(request.stepSelect, 0, "stepSelect after reset");
        checkValue(request.caSelect, 1, "caSelect after reset");
        checkValue(request.caData, 0, "caData after reset");
        checkValue(request.wayMask, 0, "wayMask after reset");
        checkValue(request.numOfData, 0, "numOfData after reset");
    endtask

    // optional second command lands while the first is running
    task automatic runProgram(input pageCommand_t c, input bit injectBusy);
        int           cycles;
        int           i;
        bit           finished;
        primRequest_t exp;
        pageCommand_t other;
        other = randomCommand();
        waitIdle();
        seenQ.delete();
        cmd = c;
        cmdValid = 1'b1;
        #1;
        checkValue(start, 1, "start on matching command");
        finished = 1'b0;
        for (cycles = 0; cycles < 200 && !finished; cycles++) begin
            @(posedge iSystemClock);
            #2;
            cmdValid = injectBusy && (cycles == 3);
            if (cmdValid) begin
                cmd = other;
                #1;
                checkValue(start, 1, "start while a program runs");
            end
            if (cycles == 0) begin
                checkValue(cmdReady, 0, "cmdReady after accept");
            end
            if (cycles == 1) begin
                checkValue(request.stepSelect, 8'h08, "setup request one cycle after accept");
                checkValue(request.caData[39:32], 8'h80, "setup byte one cycle after accept");
            end
            if (lastStep) begin
                checkValue(request.stepSelect, 0, "stepSelect during lastStep");
                checkValue(request.wayMask, c.wayMask, "wayMask during lastStep");
                finished = 1'b1;
            end
        end
        if (!finished) begin
            reportTimeout("lastStep");
        end
        @(posedge iSystemClock);
        #2;
        checkValue(lastStep, 0, "lastStep one cycle later");
        checkValue(cmdReady, 1, "cmdReady after lastStep");
        repeat (3) @(posedge iSystemClock);
        #2;
        checkValue(seenQ.size(), 4, "number of engine requests");
        for (i = 0; i < seenQ.size() && i < 4; i++) begin
            exp = expectedStep(c, i);
            checkValue(seenQ[i].stepSelect, exp.stepSelect, $sformatf("step %0d stepSelect", i));
            checkValue(seenQ[i].caSelect, exp.caSelect, $sformatf("step %0d caSelect", i));
            checkValue(seenQ[i].caData, exp.caData, $sformatf("step %0d caData", i));
            checkValue(seenQ[i].wayMask, exp.wayMask, $sformatf("step %0d wayMask", i));
            if (i == 1 || i == 2) begin
                checkValue(seenQ[i].numOfData, exp.numOfData, $sformatf("step %0d numOfData", i));
            end
        end
    endtask

    task automatic checkWrongOpcode();
        int i;
        waitIdle();
        seenQ.delete();
        cmd = makeCommand(5'd0, 16'd8, 4'b1111, 16'h0102, 24'h030405);
        cmd.opcode = 6'b000101;
        cmdValid = 1'b1;
        for (i = 0; i < 10; i++) begin
            @(posedge iSystemClock);
            #2;
            checkValue(start, 0, "start on wrong opcode");
            checkValue(cmdReady, 1, "cmdReady on wrong opcode");
            checkValue(request.stepSelect, 0, "stepSelect on wrong opcode");
        end
        cmdValid = 1'b0;
        checkValue(seenQ.size(), 0, "requests on wrong opcode");
    endtask

    initial begin
        errorCount = 0;
        timeoutCount = 0;
        rstN = 1'b0;
        cmdValid = 1'b0;
        cmd = '0;
        repeat (4) @(posedge iSystemClock);
        #2;
        rstN = 1'b1;
        checkResetValues();
        runProgram(makeCommand(5'd0, 16'd512, 4'b0101, 16'h1234, 24'h56789A), 1'b0);
        runProgram(makeCommand(5'b00001, 16'd33, 4'b1000, 16'hA7C2, 24'h123456), 1'b0);
        runProgram(makeCommand(5'b00010, 16'd7, 4'b0110, 16'h5E01, 24'hFEDCBA), 1'b0);
        checkWrongOpcode();
        runProgram(makeCommand(5'd0, 16'd64, 4'b0011, 16'h4321, 24'h0ABCDE), 1'b1);
        repeat (6) begin
            runProgram(randomCommand(), 1'b0);
        end
        $display("checks done: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/nfcProgramPage_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nfc_defines.svh"

module nfcProgramPageAssert
    import nfcProgramPkg::*;
(
    input logic         iSystemClock,
    input logic         rstN,
    input logic         cmdReady,
    input logic         lastStep,
    input primRequest_t request
);

    logic [7:0] caTopByte;

    assign caTopByte = request.caData[`CA_W-1 -: 8];

    // completion is a single-cycle pulse
    lastStepOnce: assert property (@(posedge iSystemClock) disable iff (!rstN)
        lastStep |=> !lastStep)
        else $error("lastStep held high for two cycles");

    noRequestWhenReady: assert property (@(posedge iSystemClock) disable iff (!rstN)
        cmdReady |-> (request.stepSelect == '0))
        else $error("engine request active while cmdReady is high");

    oneStepAtATime: assert property (@(posedge iSystemClock) disable iff (!rstN)
        $onehot0(request.stepSelect))
        else $error("more than one step bit set in stepSelect");

    // address and data phases never carry a command byte on top
    caSelectLowOnlyForData: assert property (@(posedge iSystemClock) disable iff (!rstN)
        !request.caSelect |-> (request.stepSelect[`STEP_DATA_OUT] ||
            !(caTopByte inside {8'h80, 8'h10, 8'h11, 8'h15})))
        else $error("caSelect low while caData carries a command byte");

endmodule

bind nfcProgramPage nfcProgramPageAssert protocolChecks (
    .iSystemClock (iSystemClock),
    .rstN         (rstN),
    .cmdReady     (cmdReady),
    .lastStep     (lastStep),
    .request      (request)
);

`default_nettype wire

// ==== hdl/nfcProgramPage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nfc_defines.svh"

module nfcProgramPage
    import nfcProgramPkg::*;
(
    input  logic               iSystemClock,
    input  logic               rstN,
    input  logic               cmdValid,
    input  pageCommand_t       cmd,
    input  logic [`PRIM_W-1:0] primDone,
    output logic               cmdReady,
    output logic               start,
    output logic               lastStep,
    output primRequest_t       request
);

    // sequencer to builder
    progState_t   nextState;
    pageCommand_t latchedCmd;

    pageProgramSequencer sequencer (
        .iSystemClock (iSystemClock),
        .rstN         (rstN),
        .cmdValid     (cmdValid),
        .cmd          (cmd),
        .primDone     (primDone),
        .cmdReady     (cmdReady),
        .start        (start),
        .lastStep     (lastStep),
        .nextState    (nextState),
        .latchedCmd   (latchedCmd)
    );

    // request registered from the state being entered
    cycleRequestBuilder builder (
        .iSystemClock (iSystemClock),
        .rstN         (rstN),
        .nextState    (nextState),
        .latchedCmd   (latchedCmd),
        .request      (request)
    );

endmodule

`default_nettype wire

// ==== hdl/cycleRequestBuilder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nfc_defines.svh"

module cycleRequestBuilder
    import nfcProgramPkg::*;
(
    input  logic         iSystemClock,
    input  logic         rstN,
    input  progState_t   nextState,
    input  pageCommand_t latchedCmd,
    output primRequest_t request
);

    localparam logic [`PRIM_W-1:0] CmdAddrStep = `PRIM_W'(1) << `STEP_CMD_ADDR;
    localparam logic [`PRIM_W-1:0] DataOutStep = `PRIM_W'(1) << `STEP_DATA_OUT;
    localparam logic [`LEN_W-1:0]  AddrCyclesM1 = `ADDR_CYCLES_M1;

    nandCmdCode_t          confirmCode;
    logic [`CA_W-1:0]      addrCycles;
    logic                  stepActive;

    // low option bits pick the confirm byte
    always_comb begin
        case (latchedCmd.option[1:0])
            2'b01:   confirmCode = confirmCache;
            2'b10:   confirmCode = confirmMultiplane;
            default: confirmCode = confirmProgram;
        endcase
    end

    // address bytes in flash cycle order, low byte first
    assign addrCycles = {latchedCmd.colAddress[7:0],
                         latchedCmd.colAddress[15:8],
                         latchedCmd.rowAddress[7:0],
                         latchedCmd.rowAddress[15:8],
                         latchedCmd.rowAddress[23:16]};

    assign stepActive = (nextState == cmdIssue) || (nextState == addrIssue) ||
                        (nextState == dataIssue) || (nextState == confirmIssue);

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            request.stepSelect <= '0;
            request.wayMask    <= '0;
            request.numOfData  <= '0;
            request.caSelect   <= 1'b1;
            request.caData     <= '0;
        end else begin
            // way mask stays put between commands
            if (stepActive) begin
                request.wayMask <= latchedCmd.wayMask;
            end
            case (nextState)
                cmdIssue: begin
                    request.stepSelect <= CmdAddrStep;
                    request.numOfData  <= '0;
                    request.caSelect   <= 1'b1;
                    request.caData     <= {setupProgram, {(`CA_W-8){1'b0}}};
                end
                addrIssue: begin
                    request.stepSelect <= CmdAddrStep;
                    request.numOfData  <= AddrCyclesM1;
                    request.caSelect   <= 1'b0;
                    request.caData     <= addrCycles;
                end
                dataIssue: begin
                    request.stepSelect <= DataOutStep;
                    request.numOfData  <= latchedCmd.length;
                    request.caSelect   <= 1'b0;
                    request.caData     <= '0;
                end
                confirmIssue: begin
                    request.stepSelect <= CmdAddrStep;
                    request.numOfData  <= '0;
                    request.caSelect   <= 1'b1;
                    request.caData     <= {confirmCode, {(`CA_W-8){1'b0}}};
                end
                default: begin
                    // idle, latch and finish issue nothing
                    request.stepSelect <= '0;
                    request.numOfData  <= '0;
                    request.caSelect   <= 1'b1;
                    request.caData     <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pageProgramSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nfc_defines.svh"

module pageProgramSequencer
    import nfcProgramPkg::*;
(
    input  logic               iSystemClock,
    input  logic               rstN,
    input  logic               cmdValid,
    input  pageCommand_t       cmd,
    input  logic [`PRIM_W-1:0] primDone,
    output logic               cmdReady,
    output logic               start,
    output logic               lastStep,
    output progState_t         nextState,
    output pageCommand_t       latchedCmd
);

    progState_t state;
    logic       accept;
    logic       cmdAddrDone;
    logic       dataOutDone;

    // opcode match, independent of state
    assign start = cmdValid && (cmd.opcode == `PROGRAM_PAGE_OPCODE);

    // only taken while waiting in idle
    assign accept = (state == idle) && start;

    // engine completion pulses per step type
    assign cmdAddrDone = primDone[`STEP_CMD_ADDR];
    assign dataOutDone = primDone[`STEP_DATA_OUT];

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (accept) begin
                    nextState = latch;
                end
            end
            latch: begin
                nextState = cmdIssue;
            end
            cmdIssue: begin
                if (cmdAddrDone) begin
                    nextState = addrIssue;
                end
            end
            addrIssue: begin
                if (cmdAddrDone) begin
                    nextState = dataIssue;
                end
            end
            dataIssue: begin
                if (dataOutDone) begin
                    nextState = confirmIssue;
                end
            end
            confirmIssue: begin
                // confirm done, one finish cycle follows
                if (cmdAddrDone) begin
                    nextState = finish;
                end
            end
            finish: begin
                nextState = idle;
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    // descriptor held for the whole program
    always_ff @(posedge iSystemClock) begin
        if (accept) begin
            latchedCmd <= cmd;
        end
    end

    // status decoded straight from the state register
    assign cmdReady = (state == idle);
    assign lastStep = (state == finish);

endmodule

`default_nettype wire

// ==== hdl/nfcProgramPkg.sv ====
`default_nettype none

`include "nfc_defines.svh"

package nfcProgramPkg;

    // sequencer states, shared with the request builder
    typedef enum logic [2:0] {
        idle         = 3'd0,
        latch        = 3'd1,
        cmdIssue     = 3'd2,
        addrIssue    = 3'd3,
        dataIssue    = 3'd4,
        confirmIssue = 3'd5,
        finish       = 3'd6
    } progState_t;

    // flash command bytes used by page program
    typedef enum logic [7:0] {
        setupProgram      = 8'h80,
        confirmProgram    = 8'h10,
        confirmMultiplane = 8'h11,
        confirmCache      = 8'h15
    } nandCmdCode_t;

    // incoming page command
    typedef struct packed {
        logic [`OPCODE_W-1:0]  opcode;
        logic [`OPTION_W-1:0]  option;
        logic [`LEN_W-1:0]     length;
        logic [`WAY_COUNT-1:0] wayMask;
        logic [`COL_W-1:0]     colAddress;
        logic [`ROW_W-1:0]     rowAddress;
    } pageCommand_t;

    // request to the primitive engine
    typedef struct packed {
        logic [`PRIM_W-1:0]    stepSelect;
        logic [`WAY_COUNT-1:0] wayMask;
        logic [`LEN_W-1:0]     numOfData;
        logic                  caSelect;
        logic [`CA_W-1:0]      caData;
    } primRequest_t;

endpackage

`default_nettype wire

// ==== hdl/nfc_defines.svh ====
`ifndef NFC_DEFINES_SVH
`define NFC_DEFINES_SVH

// flash ways, one mask bit each
`define WAY_COUNT 4

// command interface fields
`define OPCODE_W 6
`define PROGRAM_PAGE_OPCODE 6'b000011
`define OPTION_W 5
`define LEN_W 16

// page address widths
`define COL_W 16
`define ROW_W 24

// primitive engine interface
`define CA_W 40
`define PRIM_W 8
`define STEP_CMD_ADDR 3
`define STEP_DATA_OUT 2

// five address cycles, count minus one as the engine expects
`define ADDR_CYCLES_M1 4

`endif
